// File: scoreboard.f
verilog/sb_pkg.sv
verilog/sb_decode.sv
verilog/sb_issue.sv
verilog/sb_fu_entry.sv
verilog/sb_writeback.sv
verilog/scoreboard.sv
dv/scoreboard_asserts.sv
dv/scoreboard_tb.sv

// File: Bender.yml
package:
  name: scoreboard

sources:
  - verilog/sb_pkg.sv
  - verilog/sb_decode.sv
  - verilog/sb_issue.sv
  - verilog/sb_fu_entry.sv
  - verilog/sb_writeback.sv
  - verilog/scoreboard.sv
  - target: test
    files:
      - dv/scoreboard_asserts.sv
      - dv/scoreboard_tb.sv

// File: dv/scoreboard_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_tb;
    import sb_pkg::*;

    localparam int     clk_period     = 40;
    localparam int     max_done_delay = 6;
    localparam int     n_directed     = 24;
    localparam int     n_random       = 160;
    localparam int     stall_limit    = 64;
    localparam int     idle_limit     = 200;
    localparam longint watchdog_ns    =
        longint'(n_directed + n_random) * (max_done_delay + 8) * clk_period + 4 * clk_period;

    typedef struct packed {
        fu_id_e    fu;
        reg_addr_t dst;
        reg_addr_t src1;
        reg_addr_t src2;
    } dec_t;

    typedef struct packed {
        logic      busy;
        reg_addr_t dst;
        reg_addr_t src1;
        reg_addr_t src2;
        fu_id_e    q1;
        fu_id_e    q2;
        logic      rdy1;
        logic      rdy2;
        logic      read;
        logic      done;
    } model_entry_t;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_ready;
    fu_vec_t   fu_done;
    fu_vec_t   ro_en;
    ro_grant_t ro [num_fu];
    fu_vec_t   wb_en;
    wb_t       wb [num_fu];

    model_entry_t m [num_fu];       // Mirror of the unit status entries
    fu_id_e       m_rrs [num_regs];  // Mirror of the result status table

    string     test_name = "reset";
    int        mismatch_errors = 0;
    int        other_errors = 0;
    int        cycle = 0;
    int        accept_cyc;
    int        last_ro_cyc [num_fu];
    int        last_wb_cyc [num_fu];
    wb_t       last_wb [num_fu];
    fu_id_e    last_grant_fu;
    ro_grant_t last_grant;
    int        done_wait [num_fu];   // Cycles until the unit pulses done, -1 when idle
    int        done_delay [num_fu];
    logic      rand_delays = 1'b0;

    scoreboard u_scoreboard (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .fu_done    (fu_done),
        .ro_en      (ro_en),
        .ro         (ro),
        .wb_en      (wb_en),
        .wb         (wb)
    );

    always #(clk_period / 2) clk = ~clk;

    // RV32IM classes as the unit sees them
    function automatic dec_t ref_decode(inst_t w);
        dec_t       d;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       has_rd;
        logic       has_rs1;
        logic       has_rs2;
        f3      = w[14:12];
        f7      = w[31:25];
        d.fu    = fu_none;
        has_rd  = 1'b1;
        has_rs1 = 1'b1;
        has_rs2 = 1'b0;
        case (w[6:0])
            op_r: begin
                has_rs2 = 1'b1;
                if (f7 == 7'h01) begin
                    if (f3 < 3'd4) d.fu = fu_mul;
                    else d.fu = fu_div;
                end else if (f7 == 7'h00) begin
                    d.fu = fu_alu;
                end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
                    d.fu = fu_alu;  // SUB and SRA
                end
            end
            op_i: begin
                if (f3 == 3'd1) begin
                    if (f7 == 7'h00) d.fu = fu_alu;
                end else if (f3 == 3'd5) begin
                    if (f7 == 7'h00 || f7 == 7'h20) d.fu = fu_alu;
                end else begin
                    d.fu = fu_alu;
                end
            end
            op_load: begin
                if (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd4 || f3 == 3'd5) begin
                    d.fu = fu_mem;
                end
            end
            op_store: begin
                has_rd  = 1'b0;
                has_rs2 = 1'b1;
                if (f3 <= 3'd2) d.fu = fu_mem;
            end
            op_lui, op_auipc: begin
                has_rs1 = 1'b0;
                d.fu    = fu_alu;
            end
            default: begin
            end
        endcase
        d.dst  = (d.fu != fu_none && has_rd) ? w[11:7] : 5'd0;
        d.src1 = (d.fu != fu_none && has_rs1) ? w[19:15] : 5'd0;
        d.src2 = (d.fu != fu_none && has_rs2) ? w[24:20] : 5'd0;
        return d;
    endfunction

    function automatic logic wakes(fu_id_e q, fu_vec_t rel);
        if (q == fu_none) return 1'b0;
        return rel[int'(q) - 1];
    endfunction

    function automatic logic model_busy();
        logic any;
        any = 1'b0;
        for (int a = 0; a < num_fu; a++) any |= m[a].busy;
        return any;
    endfunction

    task automatic model_reset();
        for (int a = 0; a < num_fu; a++) begin
            m[a]         = '0;
            done_wait[a] = -1;
        end
        for (int r = 0; r < num_regs; r++) m_rrs[r] = fu_none;
    endtask

    // Advance the mirror by one clock edge
    task automatic model_step(input dec_t d, input logic ready, input fu_vec_t go_ro,
                              input fu_vec_t go_wb);
        fu_id_e lq1;
        fu_id_e lq2;
        int     u;
        lq1 = m_rrs[d.src1];  // Producers as seen before this edge
        lq2 = m_rrs[d.src2];
        for (int a = 0; a < num_fu; a++) begin
            if (go_wb[a]) begin
                m_rrs[m[a].dst] = fu_none;
                m[a]            = '0;
            end else if (m[a].busy) begin
                if (go_ro[a]) m[a].read = 1'b1;
                if (fu_done[a]) m[a].done = 1'b1;
                if (wakes(m[a].q1, go_wb)) m[a].rdy1 = 1'b1;
                if (wakes(m[a].q2, go_wb)) m[a].rdy2 = 1'b1;
            end
        end
        if (inst_valid && ready && d.fu != fu_none) begin
            u         = int'(d.fu) - 1;
            m[u]      = '0;
            m[u].busy = 1'b1;
            m[u].dst  = d.dst;
            m[u].src1 = d.src1;
            m[u].src2 = d.src2;
            m[u].q1   = lq1;
            m[u].q2   = lq2;
            m[u].rdy1 = (lq1 == fu_none) || wakes(lq1, go_wb);
            m[u].rdy2 = (lq2 == fu_none) || wakes(lq2, go_wb);
            if (d.dst != 5'd0) m_rrs[d.dst] = d.fu;
        end
    endtask

    task automatic check_fu(string what, fu_id_e exp, fu_id_e act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_ro(string what, ro_grant_t exp, ro_grant_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch %s %s: expected x%0d,x%0d actual x%0d,x%0d", test_name, what,
                     exp.src1, exp.src2, act.src1, act.src2);
        end
    endtask

    task automatic check_wb(string what, wb_t exp, wb_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch %s %s: expected x%0d actual x%0d", test_name, what,
                     exp.rd, act.rd);
        end
    endtask

    task automatic check_ready(string what, logic exp, logic act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_vec(string what, fu_vec_t exp, fu_vec_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_cycle(string what, int exp, int act);
        if (act != exp) begin
            mismatch_errors++;
            $display("mismatch %s %s: expected cycle %0d actual cycle %0d", test_name, what,
                     exp, act);
        end
    endtask

    // Compare every cycle on the rising edge, then advance the mirror
    always @(posedge clk) begin : compare_outputs
        dec_t      d;
        fu_vec_t   exp_ro;
        fu_vec_t   exp_wb;
        logic      exp_ready;
        logic      war;
        ro_grant_t exp_grant;
        wb_t       exp_rd;
        cycle++;
        if (rst) model_reset();
        d = ref_decode(inst);
        for (int a = 0; a < num_fu; a++) begin
            exp_ro[a] = m[a].busy && m[a].rdy1 && m[a].rdy2 && !m[a].read;
            war = 1'b0;
            for (int b = 0; b < num_fu; b++) begin
                if (b != a && m[a].dst != 5'd0 && m[b].busy && !m[b].read) begin
                    if ((m[b].rdy1 && m[b].src1 == m[a].dst) ||
                        (m[b].rdy2 && m[b].src2 == m[a].dst)) war = 1'b1;
                end
            end
            exp_wb[a] = m[a].busy && m[a].done && !war;
        end
        exp_ready = 1'b1;
        if (d.fu != fu_none) begin
            if (m[int'(d.fu) - 1].busy) exp_ready = 1'b0;  // Structural hazard
            if (d.dst != 5'd0 && m_rrs[d.dst] != fu_none) exp_ready = 1'b0;  // WAW
        end
        check_ready("inst_ready", exp_ready, inst_ready);
        check_vec("ro_en", exp_ro, ro_en);
        check_vec("wb_en", exp_wb, wb_en);
        for (int a = 0; a < num_fu; a++) begin
            exp_grant.src1 = exp_ro[a] ? m[a].src1 : 5'd0;
            exp_grant.src2 = exp_ro[a] ? m[a].src2 : 5'd0;
            exp_rd.rd      = exp_wb[a] ? m[a].dst : 5'd0;
            check_ro($sformatf("ro[%0d]", a), exp_grant, ro[a]);
            check_wb($sformatf("wb[%0d]", a), exp_rd, wb[a]);
        end
        if (!rst) begin
            for (int a = 0; a < num_fu; a++) begin
                if (ro_en[a]) begin
                    last_ro_cyc[a] = cycle;
                    last_grant_fu  = fu_id_e'(a + 1);
                    last_grant     = ro[a];
                    done_wait[a]   = rand_delays ? int'($urandom_range(max_done_delay, 0))
                                                 : done_delay[a];
                end
                if (wb_en[a]) begin
                    last_wb_cyc[a] = cycle;
                    last_wb[a]     = wb[a];
                end
            end
            if (inst_valid && exp_ready && d.fu != fu_none) accept_cyc = cycle;
            model_step(d, exp_ready, exp_ro, exp_wb);
        end
    end

    // Function units answer a grant with a done pulse after their delay
    always @(negedge clk) begin : unit_response
        for (int a = 0; a < num_fu; a++) begin
            fu_done[a] = (done_wait[a] == 0);
            if (done_wait[a] >= 0) done_wait[a]--;
        end
    end

    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_r};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_s(reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
        return {7'h00, rs2, rs1, f3, 5'h04, op_store};
    endfunction

    function automatic inst_t enc_u(reg_addr_t rd, opcode_t op);
        return {20'h1a2b3, rd, op};
    endfunction

    // Small register set keeps hazards frequent
    function automatic inst_t random_inst();
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        rd  = reg_addr_t'($urandom_range(7, 0));
        rs1 = reg_addr_t'($urandom_range(7, 0));
        rs2 = reg_addr_t'($urandom_range(7, 0));
        case ($urandom_range(9, 0))
            0: return enc_r(7'h00, rs2, rs1, 3'($urandom_range(7, 0)), rd);
            1: return enc_r(7'h20, rs2, rs1, 3'd0, rd);
            2: return enc_i(12'($urandom()), rs1, 3'd0, rd, op_i);
            3: return enc_u(rd, op_lui);
            4: return enc_i(12'h010, rs1, 3'd2, rd, op_load);
            5: return enc_s(rs2, rs1, 3'd2);
            6: return enc_r(7'h01, rs2, rs1, 3'($urandom_range(3, 0)), rd);
            7: return enc_r(7'h01, rs2, rs1, 3'($urandom_range(7, 4)), rd);
            8: return {7'h00, rs2, rs1, 3'd0, 5'h08, 7'b1100011};  // BEQ
            default: return inst_t'($urandom());
        endcase
    endfunction

    task automatic send(input inst_t w);
        int n;
        n          = 0;
        inst_valid = 1'b1;
        inst       = w;
        @(posedge clk);
        while (!inst_ready && n < stall_limit) begin
            @(posedge clk);
            n++;
        end
        if (n >= stall_limit) begin
            other_errors++;
            $display("%s: instruction %h was never accepted", test_name, w);
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (model_busy() && n < idle_limit) begin
            @(negedge clk);
            n++;
        end
        if (n >= idle_limit) begin
            other_errors++;
            $display("%s: scoreboard still busy after %0d cycles", test_name, idle_limit);
        end
    endtask

    task automatic run_dispatch(string name, inst_t w);
        dec_t      d;
        ro_grant_t exp_grant;
        wb_t       exp_rd;
        test_name     = name;
        last_grant_fu = fu_none;
        d             = ref_decode(w);
        send(w);
        wait_idle();
        repeat (2) @(negedge clk);
        check_fu("granted unit", d.fu, last_grant_fu);
        if (d.fu != fu_none) begin
            exp_grant.src1 = d.src1;
            exp_grant.src2 = d.src2;
            exp_rd.rd      = d.dst;
            check_ro("granted sources", exp_grant, last_grant);
            check_cycle("grant after accept", accept_cyc + 1, last_ro_cyc[int'(d.fu) - 1]);
            check_wb("writeback register", exp_rd, last_wb[int'(d.fu) - 1]);
        end
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog: run did not finish within %0d ns", watchdog_ns);
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'h363f_cd88));
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        fu_done    = '0;
        model_reset();
        for (int a = 0; a < num_fu; a++) begin
            done_delay[a]  = 1;
            last_ro_cyc[a] = 0;
            last_wb_cyc[a] = 0;
            last_wb[a]     = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_ready("inst_ready", 1'b1, inst_ready);
        check_vec("ro_en", '0, ro_en);
        check_vec("wb_en", '0, wb_en);

        run_dispatch("dispatch add", enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd1));
        run_dispatch("dispatch sub", enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd2));
        run_dispatch("dispatch addi", enc_i(12'h010, 5'd2, 3'd0, 5'd4, op_i));
        run_dispatch("dispatch lui", enc_u(5'd5, op_lui));
        run_dispatch("dispatch auipc", enc_u(5'd6, op_auipc));
        run_dispatch("dispatch lw", enc_i(12'h004, 5'd2, 3'd2, 5'd7, op_load));
        run_dispatch("dispatch sw", enc_s(5'd3, 5'd2, 3'd2));
        run_dispatch("dispatch mul", enc_r(7'h01, 5'd3, 5'd2, 3'd0, 5'd9));
        run_dispatch("dispatch divu", enc_r(7'h01, 5'd3, 5'd2, 3'd5, 5'd10));
        run_dispatch("dispatch beq", {7'h00, 5'd3, 5'd2, 3'd0, 5'd0, 7'b1100011});
        run_dispatch("dispatch jal", {20'h00010, 5'd1, 7'b1101111});

        test_name     = "structural stall";
        done_delay[0] = 4;
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd1));
        send(enc_r(7'h00, 5'd3, 5'd4, 3'd0, 5'd2));
        check_cycle("accept after writeback", last_wb_cyc[0] + 1, accept_cyc);
        wait_idle();

        test_name     = "waw stall";
        done_delay[2] = 4;
        send(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));
        send(enc_r(7'h00, 5'd5, 5'd4, 3'd0, 5'd3));  // Same destination as the MUL
        check_cycle("accept after writeback", last_wb_cyc[2] + 1, accept_cyc);
        wait_idle();

        test_name     = "raw wakeup";
        done_delay[2] = 3;
        send(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd4));
        send(enc_r(7'h00, 5'd0, 5'd4, 3'd0, 5'd6));
        wait_idle();
        check_cycle("consumer grant", last_wb_cyc[2] + 1, last_ro_cyc[0]);

        // DIV holds x5 ready while it waits on the MUL result x7
        test_name     = "war hold";
        done_delay[0] = 0;
        done_delay[2] = 5;
        done_delay[3] = 1;
        send(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd7));
        send(enc_r(7'h01, 5'd7, 5'd5, 3'd4, 5'd8));
        send(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));
        wait_idle();
        check_cycle("alu writeback after div read", last_ro_cyc[3] + 1, last_wb_cyc[0]);
        check_wb("alu writeback register", wb_t'(5'd5), last_wb[0]);

        test_name   = "random stream";
        rand_delays = 1'b1;
        repeat (n_random) begin
            send(random_inst());
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
        wait_idle();
        repeat (4) @(negedge clk);

        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_errors, other_errors, u_scoreboard.u_asserts.assert_fails);
        if (mismatch_errors == 0 && other_errors == 0 &&
            u_scoreboard.u_asserts.assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/scoreboard_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_asserts (
    input logic            clk,
    input logic            rst,
    input logic            inst_ready,
    input sb_pkg::fu_id_e  dec_fu,
    input sb_pkg::fu_vec_t busy,
    input sb_pkg::fu_vec_t fu_done,
    input sb_pkg::fu_vec_t ro_en,
    input sb_pkg::fu_vec_t wb_en
);
    import sb_pkg::*;

    fu_vec_t granted;  // Grant seen, done still outstanding
    logic    unit_busy;
    int      assert_fails = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            granted <= '0;
        end else begin
            granted <= (granted | ro_en) & ~fu_done;
        end
    end

    always_comb begin
        unit_busy = 1'b0;
        for (int i = 0; i < num_fu; i++) begin
            if (dec_fu == fu_id_e'(i + 1) && busy[i]) begin
                unit_busy = 1'b1;
            end
        end
    end

    a_quiet_in_reset: assert property (@(posedge clk) rst |-> (ro_en == '0 && wb_en == '0))
        else begin
            assert_fails++;
            $error("read or writeback grant while in reset");
        end

    for (genvar i = 0; i < num_fu; i++) begin : g_pulse
        a_ro_pulse: assert property (@(posedge clk) disable iff (rst) ro_en[i] |=> !ro_en[i])
            else begin
                assert_fails++;
                $error("read grant of unit %0d held longer than one cycle", i);
            end
    end

    a_done_after_grant: assert property (@(posedge clk) disable iff (rst)
                                         (fu_done & ~granted) == '0)
        else begin
            assert_fails++;
            $error("done pulse without an earlier read grant");
        end

    a_stall_on_busy: assert property (@(posedge clk) disable iff (rst) unit_busy |-> !inst_ready)
        else begin
            assert_fails++;
            $error("instruction ready although its unit is busy");
        end

endmodule

bind scoreboard scoreboard_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .inst_ready (inst_ready),
    .dec_fu     (u_issue.dec_fu),
    .busy       (busy),
    .fu_done    (fu_done),
    .ro_en      (ro_en),
    .wb_en      (wb_en)
);

`default_nettype wire

// File: verilog/scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  sb_pkg::inst_t     inst,
    output logic              inst_ready,
    input  sb_pkg::fu_vec_t   fu_done,
    output sb_pkg::fu_vec_t   ro_en,
    output sb_pkg::ro_grant_t ro [sb_pkg::num_fu],
    output sb_pkg::fu_vec_t   wb_en,
    output sb_pkg::wb_t       wb [sb_pkg::num_fu]
);
    import sb_pkg::*;

    fu_vec_t       busy;
    fu_vec_t       load;
    fu_vec_t       release_vec;
    dispatch_t     disp;
    entry_status_t status [num_fu];
    reg_addr_t     release_dst [num_fu];

    sb_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_ready  (inst_ready),
        .busy        (busy),
        .release_vec (release_vec),
        .release_dst (release_dst),
        .load        (load),
        .disp        (disp)
    );

    // Entry i tracks unit i+1 (ALU, MEM, MUL, DIV)
    for (genvar i = 0; i < num_fu; i++) begin : g_entry
        sb_fu_entry #(
            .fu_index (i)
        ) u_entry (
            .clk         (clk),
            .rst         (rst),
            .load        (load[i]),
            .disp        (disp),
            .release_vec (release_vec),
            .done_in     (fu_done[i]),
            .status      (status[i]),
            .ro_en       (ro_en[i]),
            .ro          (ro[i])
        );

        assign busy[i]        = status[i].busy;
        assign release_dst[i] = status[i].dst;
    end

    sb_writeback u_writeback (
        .status      (status),
        .release_vec (release_vec),
        .wb_en       (wb_en),
        .wb          (wb)
    );

endmodule

`default_nettype wire

// File: verilog/sb_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module sb_writeback (
    input  sb_pkg::entry_status_t status [sb_pkg::num_fu],
    output sb_pkg::fu_vec_t       release_vec,
    output sb_pkg::fu_vec_t       wb_en,
    output sb_pkg::wb_t           wb [sb_pkg::num_fu]
);
    import sb_pkg::*;

    fu_vec_t war;

    // Unit a must wait while another entry still has to read a's destination
    always_comb begin
        war = '0;
        for (int a = 0; a < num_fu; a++) begin
            for (int b = 0; b < num_fu; b++) begin
                if (b != a && status[a].dst != '0) begin
                    if ((status[b].pend1 && status[b].src1 == status[a].dst) ||
                        (status[b].pend2 && status[b].src2 == status[a].dst)) begin
                        war[a] = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int a = 0; a < num_fu; a++) begin
            wb_en[a] = status[a].busy && status[a].done && !war[a];
            wb[a].rd = wb_en[a] ? status[a].dst : '0;
        end
    end

    // Writeback frees the entry and wakes its consumers
    assign release_vec = wb_en;

endmodule

`default_nettype wire

// File: verilog/sb_fu_entry.sv
`timescale 1ns/1ps
`default_nettype none

module sb_fu_entry #(
    parameter int fu_index = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  sb_pkg::dispatch_t     disp,
    input  sb_pkg::fu_vec_t       release_vec,
    input  logic                  done_in,
    output sb_pkg::entry_status_t status,
    output logic                  ro_en,
    output sb_pkg::ro_grant_t     ro
);
    import sb_pkg::*;

    logic      busy;
    logic      rdy1;
    logic      rdy2;
    logic      read;  // Operands taken by the unit
    logic      done;
    fu_id_e    q1;
    fu_id_e    q2;
    reg_addr_t dst;
    reg_addr_t src1;
    reg_addr_t src2;

    // True when the producer q writes back this cycle
    function automatic logic woken(fu_id_e q, fu_vec_t rel);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < num_fu; i++) begin
            if (rel[i] && q == fu_id_e'(i + 1)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            rdy1 <= 1'b0;
            rdy2 <= 1'b0;
            read <= 1'b0;
            done <= 1'b0;
            q1   <= fu_none;
            q2   <= fu_none;
        end else if (release_vec[fu_index]) begin
            busy <= 1'b0;
            rdy1 <= 1'b0;
            rdy2 <= 1'b0;
            read <= 1'b0;
            done <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
            q1   <= disp.q1;
            q2   <= disp.q2;
            rdy1 <= disp.rdy1 || woken(disp.q1, release_vec);  // Same-edge writeback
            rdy2 <= disp.rdy2 || woken(disp.q2, release_vec);
            read <= 1'b0;
            done <= 1'b0;
        end else if (busy) begin
            if (ro_en) begin
                read <= 1'b1;
            end
            if (done_in) begin
                done <= 1'b1;
            end
            if (woken(q1, release_vec)) begin
                rdy1 <= 1'b1;
            end
            if (woken(q2, release_vec)) begin
                rdy2 <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dst  <= disp.dst;
            src1 <= disp.src1;
            src2 <= disp.src2;
        end
    end

    assign ro_en   = busy && rdy1 && rdy2 && !read;
    assign ro.src1 = ro_en ? src1 : '0;
    assign ro.src2 = ro_en ? src2 : '0;

    always_comb begin
        status.busy  = busy;
        status.dst   = dst;
        status.src1  = src1;
        status.src2  = src2;
        status.pend1 = busy && rdy1 && !read;  // Blocks WAR on src1
        status.pend2 = busy && rdy2 && !read;
        status.done  = done;
    end

endmodule

`default_nettype wire

// File: verilog/sb_issue.sv
`timescale 1ns/1ps
`default_nettype none

module sb_issue (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  sb_pkg::inst_t     inst,
    output logic              inst_ready,
    input  sb_pkg::fu_vec_t   busy,
    input  sb_pkg::fu_vec_t   release_vec,
    input  sb_pkg::reg_addr_t release_dst [sb_pkg::num_fu],
    output sb_pkg::fu_vec_t   load,
    output sb_pkg::dispatch_t disp
);
    import sb_pkg::*;

    fu_id_e    rrs [num_regs];  // Pending producer per register
    fu_id_e    dec_fu;
    reg_addr_t dec_dst;
    reg_addr_t dec_src1;
    reg_addr_t dec_src2;
    fu_vec_t   fu_sel;
    logic      supported;
    logic      struct_haz;
    logic      waw_haz;
    logic      accept;

    sb_decode u_decode (
        .inst (inst),
        .fu   (dec_fu),
        .dst  (dec_dst),
        .src1 (dec_src1),
        .src2 (dec_src2)
    );

    // One-hot unit select, empty for unsupported instructions
    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            fu_sel[i] = (dec_fu == fu_id_e'(i + 1));
        end
    end

    assign supported  = (dec_fu != fu_none);
    assign struct_haz = |(fu_sel & busy);
    assign waw_haz    = supported && (dec_dst != '0) && (rrs[dec_dst] != fu_none);
    assign inst_ready = !(struct_haz || waw_haz);
    assign accept     = inst_valid && inst_ready && supported;  // Unsupported just drains
    assign load       = accept ? fu_sel : '0;

    always_comb begin
        disp.dst  = dec_dst;
        disp.src1 = dec_src1;
        disp.src2 = dec_src2;
        disp.q1   = rrs[dec_src1];  // x0 slot always empty
        disp.q2   = rrs[dec_src2];
        disp.rdy1 = (disp.q1 == fu_none);
        disp.rdy2 = (disp.q2 == fu_none);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < num_regs; r++) begin
                rrs[r] <= fu_none;
            end
        end else begin
            for (int i = 0; i < num_fu; i++) begin
                if (release_vec[i]) begin
                    rrs[release_dst[i]] <= fu_none;
                end
            end
            if (accept && dec_dst != '0) begin
                rrs[dec_dst] <= dec_fu;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/sb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sb_decode (
    input  sb_pkg::inst_t     inst,
    output sb_pkg::fu_id_e    fu,
    output sb_pkg::reg_addr_t dst,
    output sb_pkg::reg_addr_t src1,
    output sb_pkg::reg_addr_t src2
);
    import sb_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;
    logic       shamt_op;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign shamt_op = (funct3 == 3'd1) || (funct3 == 3'd5);  // SLL/SRL/SRA family

    always_comb begin
        fu      = fu_none;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            op_r: begin
                if (funct7 == funct7_mext) begin
                    fu = funct3[2] ? fu_div : fu_mul;  // funct3 4-7 divide
                end else if (funct7 == funct7_base ||
                             (funct7 == funct7_alt && (funct3 == 3'd0 || funct3 == 3'd5))) begin
                    fu = fu_alu;
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_i: begin
                // Shift immediates carry funct7 in the upper bits
                if (!shamt_op || funct7 == funct7_base ||
                    (funct7 == funct7_alt && funct3 == 3'd5)) begin
                    fu = fu_alu;
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            op_load: begin
                if (funct3 != 3'd3 && funct3 < 3'd6) begin
                    fu = fu_mem;  // LB LH LW LBU LHU
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            op_store: begin
                if (funct3 < 3'd3) begin
                    fu = fu_mem;
                end
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_lui, op_auipc: begin
                fu     = fu_alu;
                use_rd = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Fields zeroed when unused or unsupported
    assign dst  = (fu != fu_none && use_rd)  ? inst[11:7]  : '0;
    assign src1 = (fu != fu_none && use_rs1) ? inst[19:15] : '0;
    assign src2 = (fu != fu_none && use_rs2) ? inst[24:20] : '0;

endmodule

`default_nettype wire

// File: verilog/sb_pkg.sv
`default_nettype none

package sb_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_fu     = 4;
    localparam int num_regs   = 1 << reg_addr_w;

    typedef logic [xlen-1:0]       inst_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [num_fu-1:0]     fu_vec_t;
    typedef logic [6:0]            opcode_t;

    // Producing unit, entry i serves unit i+1
    typedef enum logic [2:0] {
        fu_none = 3'd0,
        fu_alu  = 3'd1,
        fu_mem  = 3'd2,
        fu_mul  = 3'd3,
        fu_div  = 3'd4
    } fu_id_e;

    // RV32IM major opcodes
    localparam opcode_t op_r     = 7'b0110011;
    localparam opcode_t op_i     = 7'b0010011;
    localparam opcode_t op_load  = 7'b0000011;
    localparam opcode_t op_store = 7'b0100011;
    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_auipc = 7'b0010111;

    localparam logic [6:0] funct7_base = 7'h00;
    localparam logic [6:0] funct7_alt  = 7'h20;  // SUB, SRA, SRAI
    localparam logic [6:0] funct7_mext = 7'h01;

    typedef struct packed {
        reg_addr_t dst;
        reg_addr_t src1;
        reg_addr_t src2;
        fu_id_e    q1;
        fu_id_e    q2;
        logic      rdy1;
        logic      rdy2;
    } dispatch_t;

    // pend = operand ready but not yet read
    typedef struct packed {
        logic      busy;
        reg_addr_t dst;
        reg_addr_t src1;
        reg_addr_t src2;
        logic      pend1;
        logic      pend2;
        logic      done;
    } entry_status_t;

    typedef struct packed {
        reg_addr_t src1;
        reg_addr_t src2;
    } ro_grant_t;

    typedef struct packed {
        reg_addr_t rd;
    } wb_t;

endpackage

`default_nettype wire
